// File: sim.f
hw/isa_pkg.sv
hw/mem_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/regfile.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/core_top.sv
test/core_checker.sv
test/tb_core.sv

// File: Makefile
TOP = tb_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qx 'TESTBENCH PASSED' sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_core.sv
`timescale 1ns/1ps

module tb_core;
    import isa_pkg::*;
    import mem_pkg::*;

    localparam int    SEED           = 74331;
    localparam int    NUM_INSTS      = 200;
    localparam int    PROG_WORDS     = 256;            // program plus nop padding
    localparam int    DATA_WORDS     = 64;
    localparam addr_t DATA_BASE      = 32'h0000_0100;
    localparam int    RESET_CYCLES   = 10;
    localparam int    TIMEOUT_CYCLES = NUM_INSTS * 40 + RESET_CYCLES;

    logic     clk;
    logic     reset;
    logic     inst_req;
    addr_t    inst_addr;
    logic     inst_ack;
    word_t    inst_data;
    logic     data_req;
    logic     data_we;
    addr_t    data_addr;
    word_t    data_wdata;
    logic     data_ack;
    word_t    data_rdata;
    logic     commit_valid;
    addr_t    commit_pc;
    word_t    commit_inst;
    logic     commit_wen;
    reg_idx_t commit_wdest;
    word_t    commit_wdata;

    integer   seed;        // program generator
    integer   inst_seed;   // fetch responder delays
    integer   data_seed;   // data responder delays

    word_t    prog       [PROG_WORDS];
    word_t    dmem       [DATA_WORDS];   // what the data responder serves
    word_t    model_mem  [DATA_WORDS];
    word_t    model_regs [NUM_REGS];
    addr_t    exp_addr[$];               // stores in program order
    word_t    exp_data[$];
    addr_t    got_addr[$];               // stores as seen on the port
    word_t    got_data[$];
    int       commit_count;
    int       cycle_count;

    core_top dut (
        .clk(clk), .reset(reset),
        .inst_req(inst_req), .inst_addr(inst_addr),
        .inst_ack(inst_ack), .inst_data(inst_data),
        .data_req(data_req), .data_we(data_we),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_ack(data_ack), .data_rdata(data_rdata),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_inst(commit_inst),
        .commit_wen(commit_wen), .commit_wdest(commit_wdest), .commit_wdata(commit_wdata)
    );

    always #4 clk = ~clk;   // 8 ns period

    function automatic word_t encode(input opcode_t op, input reg_idx_t rd,
                                     input reg_idx_t rs1, input reg_idx_t rs2,
                                     input imm_t imm);
        word_t w;
        w = '0;
        w[OPC_HI:OPC_LO] = op;
        w[RD_HI:RD_LO]   = rd;
        w[RS1_HI:RS1_LO] = rs1;
        w[RS2_HI:RS2_LO] = rs2;
        w[IMM_HI:IMM_LO] = imm;
        return w;
    endfunction

    // initial data contents, every address bit mixed in
    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h00c0_ffee;
    endfunction

    function automatic int mem_index(input addr_t a);
        addr_t off;
        off = a - DATA_BASE;
        return int'(off[7:2]);
    endfunction

    function automatic word_t fetch_word(input addr_t a);
        if (a[31:10] != '0) begin
            return encode(OP_NOP, '0, '0, '0, '0);   // far past the program
        end
        return prog[a[9:2]];
    endfunction

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] time %0t %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("[FAIL] time %0t %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] time %0t %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_data_range(input addr_t a);
        addr_t off;
        off = a - DATA_BASE;
        if (off >= addr_t'(DATA_WORDS * 4) || off[1:0] != 2'b00) begin
            $display("ERROR at time %0t: data access to %h is outside the data area", $time, a);
            stop_run();
        end
    endtask

    // 0 to 5 falling edges
    task automatic random_wait(inout integer s);
        int cycles;
        cycles = $unsigned($random(s)) % 6;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic build_program();
        word_t      rnd;
        word_t      rnd2;
        opcode_t    op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   last_rd;
        imm_t       imm;
        logic [5:0] widx;
        logic [5:0] last_widx;
        int         i;
        last_rd   = '0;
        last_widx = '0;
        for (i = 0; i < PROG_WORDS; i++) begin
            prog[i] = encode(OP_NOP, '0, '0, '0, '0);
        end
        for (i = 0; i < NUM_INSTS; i++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            op   = opcode_t'({1'b0, rnd[2:0]});
            rd   = rnd[7:4];
            rs1  = rnd[8]  ? last_rd : rnd[12:9];   // half the time read the last result
            rs2  = rnd[13] ? last_rd : rnd[17:14];
            imm  = rnd[31:16];
            if (op == OP_LW || op == OP_SW) begin
                widx      = rnd2[0] ? last_widx : rnd2[6:1];   // store then load same word
                rs1       = '0;                                // r0 base, address = imm
                imm       = imm_t'(DATA_BASE) + {8'h00, widx, 2'b00};
                last_widx = widx;
            end
            if (op != OP_NOP && op != OP_SW) begin
                last_rd = rd;
            end
            prog[i] = encode(op, rd, rs1, rs2, imm);
        end
    endtask

    // isa model, one instruction per commit
    task automatic model_commit(input int n);
        word_t    ins;
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    a;
        word_t    b;
        word_t    sext;
        word_t    val;
        addr_t    addr;
        logic     wen;
        ins  = prog[n];
        op   = opcode_t'(ins[OPC_HI:OPC_LO]);
        rd   = ins[RD_HI:RD_LO];
        rs1  = ins[RS1_HI:RS1_LO];
        rs2  = ins[RS2_HI:RS2_LO];
        a    = model_regs[rs1];
        b    = model_regs[rs2];
        sext = {{16{ins[IMM_HI]}}, ins[IMM_HI:IMM_LO]};
        addr = a + sext;
        val  = '0;
        wen  = 1'b1;
        case (op)
            OP_ADD:  val = a + b;
            OP_SUB:  val = a - b;
            OP_AND:  val = a & b;
            OP_XOR:  val = a ^ b;
            OP_ADDI: val = a + sext;
            OP_LW:   val = model_mem[mem_index(addr)];
            OP_SW: begin
                wen = 1'b0;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
                model_mem[mem_index(addr)] = b;
            end
            default: wen = 1'b0;   // nop
        endcase
        check_word("commit_pc", addr_t'(n * 4), commit_pc);
        check_word("commit_inst", ins, commit_inst);
        check_bit("commit_wen", wen, commit_wen);
        if (wen) begin
            check_reg("commit_wdest", rd, commit_wdest);
            check_word("commit_wdata", val, commit_wdata);
        end
        if (wen && rd != '0) begin
            model_regs[rd] = val;   // r0 stays zero
        end
    endtask

    task automatic check_stores();
        int i;
        check_word("store_count", word_t'(exp_addr.size()), word_t'(got_addr.size()));
        for (i = 0; i < exp_addr.size(); i++) begin
            check_word("data_addr", exp_addr[i], got_addr[i]);
            check_word("data_wdata", exp_data[i], got_data[i]);
        end
    endtask

    // instruction memory responder
    initial begin : inst_responder
        forever begin
            @(negedge clk);
            if (!reset && inst_req && !inst_ack) begin
                random_wait(inst_seed);
                inst_data = fetch_word(inst_addr);
                inst_ack  = 1'b1;
                while (inst_req) @(negedge clk);
                random_wait(inst_seed);
                inst_ack = 1'b0;
            end
        end
    end

    // data memory responder, logs stores in port order
    initial begin : data_responder
        int idx;
        forever begin
            @(negedge clk);
            if (!reset && data_req && !data_ack) begin
                random_wait(data_seed);
                check_data_range(data_addr);
                idx = mem_index(data_addr);
                if (data_we) begin
                    dmem[idx] = data_wdata;
                    got_addr.push_back(data_addr);
                    got_data.push_back(data_wdata);
                end else begin
                    data_rdata = dmem[idx];
                end
                data_ack = 1'b1;
                while (data_req) @(negedge clk);
                random_wait(data_seed);
                data_ack = 1'b0;
            end
        end
    end

    // commit outputs are registered, stable at the falling edge
    always @(negedge clk) begin
        if (!reset && commit_valid && commit_count < NUM_INSTS) begin
            model_commit(commit_count);
            commit_count = commit_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, %0d of %0d instructions committed in %0d cycles",
                     commit_count, NUM_INSTS, cycle_count);
            stop_run();
        end
    end

    initial begin
        int i;
        clk          = 1'b0;
        reset        = 1'b1;
        inst_ack     = 1'b0;
        inst_data    = '0;
        data_ack     = 1'b0;
        data_rdata   = '0;
        seed         = SEED;
        inst_seed    = SEED + 1;
        data_seed    = SEED + 2;
        commit_count = 0;
        cycle_count  = 0;
        for (i = 0; i < DATA_WORDS; i++) begin
            dmem[i]      = fill_word(DATA_BASE + addr_t'(i * 4));
            model_mem[i] = dmem[i];
        end
        for (i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;   // core clears its registers on reset
        end
        build_program();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        while (commit_count < NUM_INSTS) @(negedge clk);
        check_stores();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: test/core_checker.sv
`timescale 1ns/1ps

module core_checker (
    input  logic           clk,
    input  logic           reset,
    input  logic           inst_req,
    input  logic           inst_ack,
    input  mem_pkg::addr_t inst_addr,
    input  logic           data_req,
    input  logic           data_ack,
    input  mem_pkg::addr_t data_addr,
    input  mem_pkg::word_t data_wdata,
    input  logic           commit_valid
);

    // request side holds its fields until the responder answers
    inst_addr_stable: assert property (@(posedge clk) disable iff (reset)
        inst_req && !inst_ack |=> $stable(inst_addr))
        else $error("inst_addr moved while inst_req waited for inst_ack");

    data_addr_stable: assert property (@(posedge clk) disable iff (reset)
        data_req && !data_ack |=> $stable(data_addr) && $stable(data_wdata))
        else $error("data_addr or data_wdata moved while data_req waited for data_ack");

    // new request only after the previous ack has fallen
    inst_req_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(inst_req) |-> !$past(inst_ack))
        else $error("inst_req rose while inst_ack was still high");

    data_req_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(data_req) |-> !$past(data_ack))
        else $error("data_req rose while data_ack was still high");

    commit_quiet: assert property (@(posedge clk)
        reset |=> !commit_valid)
        else $error("commit_valid high during reset");

endmodule

bind core_top core_checker u_checker (
    .clk(clk),
    .reset(reset),
    .inst_req(inst_req),
    .inst_ack(inst_ack),
    .inst_addr(inst_addr),
    .data_req(data_req),
    .data_ack(data_ack),
    .data_addr(data_addr),
    .data_wdata(data_wdata),
    .commit_valid(commit_valid)
);

// File: hw/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic              clk,
    input  logic              reset,
    output logic              inst_req,
    output mem_pkg::addr_t    inst_addr,
    input  logic              inst_ack,
    input  mem_pkg::word_t    inst_data,
    output logic              data_req,
    output logic              data_we,
    output mem_pkg::addr_t    data_addr,
    output mem_pkg::word_t    data_wdata,
    input  logic              data_ack,
    input  mem_pkg::word_t    data_rdata,
    output logic              commit_valid,
    output mem_pkg::addr_t    commit_pc,
    output mem_pkg::word_t    commit_inst,
    output logic              commit_wen,
    output isa_pkg::reg_idx_t commit_wdest,
    output mem_pkg::word_t    commit_wdata
);
    import isa_pkg::*;
    import mem_pkg::*;

    // fetch to decode
    logic     if_valid;
    logic     if_ready;
    addr_t    if_pc;
    word_t    if_inst;

    // decode and register file
    reg_idx_t rf_index1;
    reg_idx_t rf_index2;
    word_t    rf_data1;
    word_t    rf_data2;
    logic     id_valid;
    logic     id_ready;
    addr_t    id_pc;
    word_t    id_inst;
    opcode_t  id_op;
    reg_idx_t id_rd;
    logic     id_wen;
    word_t    id_a;
    word_t    id_b;
    word_t    id_store_data;

    // execute to memory
    logic     ex_valid;
    logic     ex_ready;
    addr_t    ex_pc;
    word_t    ex_inst;
    logic     ex_is_load;
    logic     ex_is_store;
    reg_idx_t ex_rd;
    logic     ex_wen;
    word_t    ex_result;
    word_t    ex_store_data;
    logic     mem_busy_load;

    fetch_stage u_fetch (
        .clk(clk), .reset(reset),
        .inst_ack(inst_ack), .inst_data(inst_data), .ready(if_ready),
        .inst_req(inst_req), .inst_addr(inst_addr),
        .valid(if_valid), .pc(if_pc), .inst(if_inst)
    );

    decode_stage u_decode (
        .clk(clk), .reset(reset),
        .in_valid(if_valid), .pc(if_pc), .inst(if_inst),
        .rf_data1(rf_data1), .rf_data2(rf_data2),
        .ex_valid(ex_valid), .ex_is_load(ex_is_load), .ex_rd(ex_rd),
        .ex_wen(ex_wen), .ex_result(ex_result),
        .mem_busy_load(mem_busy_load), .mem_rd(commit_wdest),   // rd of the pending load
        .out_ready(id_ready), .in_ready(if_ready),
        .rf_index1(rf_index1), .rf_index2(rf_index2),
        .out_valid(id_valid), .out_pc(id_pc), .out_inst(id_inst), .out_op(id_op),
        .out_rd(id_rd), .out_wen(id_wen), .out_a(id_a), .out_b(id_b),
        .out_store_data(id_store_data)
    );

    // written from the commit register, commit_wen is already a pulse
    regfile u_regfile (
        .clk(clk), .reset(reset),
        .index1(rf_index1), .index2(rf_index2),
        .wen(commit_wen), .wdest(commit_wdest), .wdata(commit_wdata),
        .data1(rf_data1), .data2(rf_data2)
    );

    execute_stage u_execute (
        .clk(clk), .reset(reset),
        .in_valid(id_valid), .pc(id_pc), .inst(id_inst), .op(id_op),
        .rd(id_rd), .wen(id_wen), .a(id_a), .b(id_b), .store_data(id_store_data),
        .out_ready(ex_ready), .in_ready(id_ready),
        .out_valid(ex_valid), .out_pc(ex_pc), .out_inst(ex_inst),
        .out_is_load(ex_is_load), .out_is_store(ex_is_store),
        .out_rd(ex_rd), .out_wen(ex_wen), .out_result(ex_result),
        .out_store_data(ex_store_data)
    );

    memory_stage u_memory (
        .clk(clk), .reset(reset),
        .in_valid(ex_valid), .pc(ex_pc), .inst(ex_inst),
        .is_load(ex_is_load), .is_store(ex_is_store), .rd(ex_rd), .wen(ex_wen),
        .result(ex_result), .store_data(ex_store_data),
        .data_ack(data_ack), .data_rdata(data_rdata),
        .in_ready(ex_ready), .busy_load(mem_busy_load),
        .data_req(data_req), .data_we(data_we),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_inst(commit_inst),
        .commit_wen(commit_wen), .commit_wdest(commit_wdest), .commit_wdata(commit_wdata)
    );

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  mem_pkg::addr_t    pc,
    input  mem_pkg::word_t    inst,
    input  logic              is_load,
    input  logic              is_store,
    input  isa_pkg::reg_idx_t rd,
    input  logic              wen,
    input  mem_pkg::word_t    result,
    input  mem_pkg::word_t    store_data,
    input  logic              data_ack,
    input  mem_pkg::word_t    data_rdata,
    output logic              in_ready,
    output logic              busy_load,
    output logic              data_req,
    output logic              data_we,
    output mem_pkg::addr_t    data_addr,
    output mem_pkg::word_t    data_wdata,
    output logic              commit_valid,
    output mem_pkg::addr_t    commit_pc,
    output mem_pkg::word_t    commit_inst,
    output logic              commit_wen,
    output isa_pkg::reg_idx_t commit_wdest,
    output mem_pkg::word_t    commit_wdata
);
    import mem_pkg::*;

    req_phase_t phase;
    logic       hold_wen;   // wen of the access in flight

    // commit register doubles as the hold register during an access
    assign in_ready  = (phase == PH_IDLE);
    assign busy_load = (phase != PH_IDLE) && !data_we;   // commit_wdest is its rd

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= PH_IDLE;
            data_req     <= 1'b0;
            commit_valid <= 1'b0;
            commit_wen   <= 1'b0;
        end else begin
            commit_valid <= 1'b0;   // one-cycle pulse
            commit_wen   <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (in_valid && (is_load || is_store)) begin
                        data_req <= 1'b1;
                        phase    <= PH_REQ;
                    end else if (in_valid) begin
                        commit_valid <= 1'b1;   // alu item goes straight through
                        commit_wen   <= wen;
                    end
                end
                PH_REQ: begin
                    if (data_ack) begin
                        data_req <= 1'b0;
                        phase    <= PH_DROP;
                    end
                end
                PH_DROP: begin
                    if (!data_ack) begin
                        commit_valid <= 1'b1;
                        commit_wen   <= hold_wen;
                        phase        <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && in_valid) begin
            commit_pc    <= pc;
            commit_inst  <= inst;
            commit_wdest <= rd;
            commit_wdata <= result;
            hold_wen     <= wen;
            data_we      <= is_store;
            data_addr    <= result;       // effective address from execute
            data_wdata   <= store_data;
        end else if (phase == PH_REQ && data_ack && !data_we) begin
            commit_wdata <= data_rdata;   // load data replaces the address
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  mem_pkg::addr_t    pc,
    input  mem_pkg::word_t    inst,
    input  isa_pkg::opcode_t  op,
    input  isa_pkg::reg_idx_t rd,
    input  logic              wen,
    input  mem_pkg::word_t    a,
    input  mem_pkg::word_t    b,
    input  mem_pkg::word_t    store_data,
    input  logic              out_ready,
    output logic              in_ready,
    output logic              out_valid,
    output mem_pkg::addr_t    out_pc,
    output mem_pkg::word_t    out_inst,
    output logic              out_is_load,
    output logic              out_is_store,
    output isa_pkg::reg_idx_t out_rd,
    output logic              out_wen,
    output mem_pkg::word_t    out_result,
    output mem_pkg::word_t    out_store_data
);
    import isa_pkg::*;
    import mem_pkg::*;

    word_t alu_out;

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI, OP_LW, OP_SW: alu_out = a + b;   // address gen shares the adder
            OP_SUB:  alu_out = a - b;
            OP_AND:  alu_out = a & b;
            OP_XOR:  alu_out = a ^ b;
            default: alu_out = '0;
        endcase
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_pc         <= pc;
            out_inst       <= inst;
            out_is_load    <= (op == OP_LW);    // decode needs this for load-use
            out_is_store   <= (op == OP_SW);
            out_rd         <= rd;
            out_wen        <= wen;
            out_result     <= alu_out;
            out_store_data <= store_data;
        end
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::reg_idx_t index1,
    input  isa_pkg::reg_idx_t index2,
    input  logic              wen,
    input  isa_pkg::reg_idx_t wdest,
    input  mem_pkg::word_t    wdata,
    output mem_pkg::word_t    data1,
    output mem_pkg::word_t    data2
);
    import isa_pkg::*;
    import mem_pkg::*;

    word_t regs [1:NUM_REGS-1];   // no storage behind r0

    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wen && wdest == idx) begin
            return wdata;   // write-through, same-cycle commit visible
        end
        return regs[idx];
    endfunction

    always_comb begin
        data1 = read_port(index1);
        data2 = read_port(index2);
    end

    // cleared on reset so the core starts from all-zero registers
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && wdest != '0) begin
            regs[wdest] <= wdata;
        end
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  mem_pkg::addr_t    pc,
    input  mem_pkg::word_t    inst,
    input  mem_pkg::word_t    rf_data1,
    input  mem_pkg::word_t    rf_data2,
    input  logic              ex_valid,
    input  logic              ex_is_load,
    input  isa_pkg::reg_idx_t ex_rd,
    input  logic              ex_wen,
    input  mem_pkg::word_t    ex_result,
    input  logic              mem_busy_load,
    input  isa_pkg::reg_idx_t mem_rd,
    input  logic              out_ready,
    output logic              in_ready,
    output isa_pkg::reg_idx_t rf_index1,
    output isa_pkg::reg_idx_t rf_index2,
    output logic              out_valid,
    output mem_pkg::addr_t    out_pc,
    output mem_pkg::word_t    out_inst,
    output isa_pkg::opcode_t  out_op,
    output isa_pkg::reg_idx_t out_rd,
    output logic              out_wen,
    output mem_pkg::word_t    out_a,
    output mem_pkg::word_t    out_b,
    output mem_pkg::word_t    out_store_data
);
    import isa_pkg::*;
    import mem_pkg::*;

    opcode_t  op;
    reg_idx_t rd;
    imm_t     imm;
    word_t    imm_ext;
    logic     reads1;
    logic     reads2;
    logic     use_imm;     // operand b from the immediate
    logic     writes;
    word_t    src1;
    word_t    src2;
    logic     stall;

    // bypass from the execute output register, loads excluded
    function automatic word_t forward(input reg_idx_t idx, input word_t rf_val);
        if (ex_valid && ex_wen && !ex_is_load && idx != '0 && ex_rd == idx) begin
            return ex_result;
        end
        return rf_val;
    endfunction

    // result not yet available anywhere
    // writer still sits in this output register, or a load is in flight
    function automatic logic result_pending(input reg_idx_t idx);
        return (idx != '0) &&
               ((out_valid && out_wen && out_rd == idx) ||
                (ex_valid && ex_is_load && ex_rd == idx) ||
                (mem_busy_load && mem_rd == idx));
    endfunction

    assign rf_index1 = inst[RS1_HI:RS1_LO];
    assign rf_index2 = inst[RS2_HI:RS2_LO];

    always_comb begin
        op      = opcode_t'(inst[OPC_HI:OPC_LO]);
        rd      = inst[RD_HI:RD_LO];
        imm     = inst[IMM_HI:IMM_LO];
        imm_ext = {{16{imm[IMM_HI]}}, imm};
        reads1  = 1'b0;
        reads2  = 1'b0;
        use_imm = 1'b0;
        writes  = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                reads1 = 1'b1;
                reads2 = 1'b1;
                writes = 1'b1;
            end
            OP_ADDI, OP_LW: begin
                reads1  = 1'b1;
                use_imm = 1'b1;
                writes  = 1'b1;   // r0 target still commits with wen
            end
            OP_SW: begin
                reads1  = 1'b1;
                reads2  = 1'b1;   // store data
                use_imm = 1'b1;
            end
            default: ;            // nop and unused codes do nothing
        endcase
    end

    always_comb begin
        src1  = forward(rf_index1, rf_data1);
        src2  = forward(rf_index2, rf_data2);
        stall = in_valid && ((reads1 && result_pending(rf_index1)) ||
                             (reads2 && result_pending(rf_index2)));
    end

    assign in_ready = (!out_valid || out_ready) && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (!out_valid || out_ready) begin
            out_valid <= in_valid && !stall;   // bubble while a source is pending
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_pc         <= pc;
            out_inst       <= inst;
            out_op         <= op;
            out_rd         <= rd;
            out_wen        <= writes;
            out_a          <= src1;
            out_b          <= use_imm ? imm_ext : src2;
            out_store_data <= src2;
        end
    end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           inst_ack,
    input  mem_pkg::word_t inst_data,
    input  logic           ready,
    output logic           inst_req,
    output mem_pkg::addr_t inst_addr,
    output logic           valid,
    output mem_pkg::addr_t pc,
    output mem_pkg::word_t inst
);
    import mem_pkg::*;

    req_phase_t phase;
    addr_t      fetch_pc;   // address of the fetch in flight
    logic       out_free;

    assign out_free  = !valid || ready;   // output register empty after this edge
    assign inst_addr = fetch_pc;          // stable for the whole handshake

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= PH_IDLE;
            inst_req <= 1'b0;
            valid    <= 1'b0;
            fetch_pc <= RESET_PC;
        end else begin
            if (valid && ready) begin
                valid <= 1'b0;   // decode took it
            end
            case (phase)
                PH_IDLE: begin
                    // only start when the result has somewhere to go
                    if (out_free && !inst_ack) begin
                        inst_req <= 1'b1;
                        phase    <= PH_REQ;
                    end
                end
                PH_REQ: begin
                    if (inst_ack) begin
                        inst_req <= 1'b0;
                        phase    <= PH_DROP;
                    end
                end
                PH_DROP: begin
                    if (!inst_ack) begin
                        valid    <= 1'b1;                  // handshake closed
                        fetch_pc <= fetch_pc + addr_t'(4);
                        phase    <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // output register is empty for the whole fetch, so capture at ack
    always_ff @(posedge clk) begin
        if (phase == PH_REQ && inst_ack) begin
            pc   <= fetch_pc;
            inst <= inst_data;
        end
    end

endmodule

// File: hw/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;   // byte address, low two bits ignored

    localparam addr_t RESET_PC = 32'h0;

    // phases of one four-phase req/ack transfer
    typedef enum logic [1:0] {
        PH_IDLE,   // req low, ack low
        PH_REQ,    // req high, waiting for ack
        PH_DROP    // req dropped, waiting for ack to fall
    } req_phase_t;

endpackage

// File: hw/isa_pkg.sv
package isa_pkg;

    typedef logic [3:0]  reg_idx_t;   // register index
    typedef logic [15:0] imm_t;       // raw immediate, sign-extended where used

    // opcode field values
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDI = 4'd5,   // rd = rs1 + imm
        OP_LW   = 4'd6,   // rd = mem[rs1 + imm]
        OP_SW   = 4'd7    // mem[rs1 + imm] = rs2, no register write
    } opcode_t;

    localparam int NUM_REGS = 16;   // r0 always reads zero

    // field positions in the 32-bit instruction word
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 28;
    localparam int RD_HI  = 27;
    localparam int RD_LO  = 24;
    localparam int RS1_HI = 23;
    localparam int RS1_LO = 20;
    localparam int RS2_HI = 19;
    localparam int RS2_LO = 16;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

endpackage
